// ==== include/rom_defs.svh ====
// Widths, store size and key codes shared by the ROM subsystem.
// The store holds 48K bytes; the sound region starts at download byte 16'h8000.
// Scan codes are PS/2 set 2 make codes without the extended prefix.
`ifndef ROM_DEFS_SVH
`define ROM_DEFS_SVH

//============================================================
// Core ROM bus widths
//============================================================
`define CPU_ROM_AW 15 // CPU byte address
`define SND_ROM_AW 14 // Sound byte address

//============================================================
// Store layout
//============================================================
`define SND_BASE_WORD 16'h4000 // First word of the sound region
`define STORE_WORDS 24576      // 48K bytes as 16-bit words

//============================================================
// Keyboard scan codes
//============================================================
`define KEY_UP 8'h75
`define KEY_DOWN 8'h72
`define KEY_LEFT 8'h6B
`define KEY_RIGHT 8'h74
`define KEY_COIN 8'h76   // Esc
`define KEY_START1 8'h05 // F1
`define KEY_START2 8'h06 // F2
`define KEY_FIRE 8'h29   // Space

`endif

// ==== design/arcade_pkg.sv ====
// Types shared by the ROM subsystem.
// Store words are little endian with the low byte at the even byte address.
`default_nettype none

package arcade_pkg;

	// Byte handed back to the core
	typedef logic [7:0] rom_byte_t;

	// One store word, low byte at the even address
	typedef logic [15:0] rom_word_t;

	// Byte address of the download stream
	typedef logic [15:0] dl_addr_t;

	// Word address into the ROM array
	typedef logic [14:0] store_addr_t;

	// Keyboard scan code
	typedef logic [7:0] scan_code_t;

	// Joystick bits
	// 4 fire, 3 up, 2 down, 1 left, 0 right
	typedef logic [7:0] joy_t;

	// Store read sequencer
	typedef enum logic [1:0] {
		st_idle,     // Waiting for a pending read
		st_read_cpu, // Reading for the CPU bus
		st_read_snd  // Reading for the sound bus
	} store_state_t;

endpackage

`default_nettype wire

// ==== design/rom_port.sv ====
// One core ROM bus in front of the shared store.
// A fetch starts only when the word address changes; one fetch in flight at a time.
// The core may move its address while waiting; the new word is fetched after done.
`default_nettype none

`include "rom_defs.svh"

module rom_port import arcade_pkg::*; #(
	parameter int ADDR_W = `CPU_ROM_AW,
	parameter int unsigned BASE_WORD = 0
) (
	input  wire logic              clk_sys,
	input  wire logic              rst_n,
	input  wire logic              download,
	input  wire logic              rd,
	input  wire logic [ADDR_W-1:0] addr,
	input  wire logic              done,
	input  wire rom_word_t         q,
	output logic                   req,
	output store_addr_t            word_addr,
	output rom_byte_t              data,
	output logic                   wait_rom
);

	// One bit wider than the word address, so all ones never matches a real word
	logic [ADDR_W-1:0] last_word;
	logic [ADDR_W-2:0] core_word;
	logic              new_word;
	rom_word_t         held;

	assign core_word = addr[ADDR_W-1:1];
	assign new_word  = rd && (last_word != {1'b0, core_word});

	//============================================================
	// Request and wait control
	//============================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			last_word <= '1;
			req       <= 1'b0;
			wait_rom  <= 1'b0;
		end else begin
			req <= 1'b0; // Single-cycle pulse
			if (download) begin
				last_word <= '1; // Force a fetch after the download
			end else if (!wait_rom && new_word) begin
				last_word <= {1'b0, core_word};
				req       <= 1'b1;
				wait_rom  <= 1'b1;
			end
			if (done)
				wait_rom <= 1'b0;
		end
	end

	// Store address of the requested word
	always_ff @(posedge clk_sys) begin
		if (!download && !wait_rom && new_word)
			word_addr <= store_addr_t'(BASE_WORD) + store_addr_t'(core_word);
	end

	// Returned word, kept until the next fetch
	always_ff @(posedge clk_sys) begin
		if (done)
			held <= q;
	end

	// Byte lane follows address bit 0 directly
	assign data = addr[0] ? held[15:8] : held[7:0];

endmodule

`default_nettype wire

// ==== design/rom_store.sv ====
// Single-cycle synchronous array standing in for the SDRAM.
// Download writes go in byte by byte and hold off new reads while they run.
// Two read clients with the CPU ahead of sound; each read takes two cycles from req to done.
`default_nettype none

`include "rom_defs.svh"

module rom_store import arcade_pkg::*; (
	input  wire logic        clk_sys,
	input  wire logic        rst_n,
	input  wire logic        download,
	input  wire logic        dl_wr,
	input  wire dl_addr_t    dl_addr,
	input  wire rom_byte_t   dl_data,
	input  wire logic        cpu_req,
	input  wire store_addr_t cpu_addr,
	input  wire logic        snd_req,
	input  wire store_addr_t snd_addr,
	output logic             cpu_done,
	output logic             snd_done,
	output rom_word_t        q
);

	rom_word_t mem [0:`STORE_WORDS-1];

	store_state_t state;

	logic        cpu_pend;
	logic        snd_pend;
	store_addr_t cpu_addr_r;
	store_addr_t snd_addr_r;

	logic        wr_pend;   // Write committing this cycle
	store_addr_t wr_addr_r;
	rom_byte_t   wr_data_r;
	logic        wr_hi_r;   // Odd byte goes to the upper lane

	logic rd_block;

	// No new read starts while the download owns the array
	assign rd_block = download | dl_wr;

	//============================================================
	// Request capture and read sequencing
	//============================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			cpu_pend <= 1'b0;
			snd_pend <= 1'b0;
			cpu_done <= 1'b0;
			snd_done <= 1'b0;
			wr_pend  <= 1'b0;
		end else begin
			cpu_done <= 1'b0;
			snd_done <= 1'b0;
			wr_pend  <= dl_wr;
			case (state)
				st_idle: begin
					if (!rd_block) begin
						if (cpu_pend || cpu_req)
							state <= st_read_cpu; // CPU first
						else if (snd_pend || snd_req)
							state <= st_read_snd;
					end
				end
				st_read_cpu: begin
					cpu_done <= 1'b1;
					cpu_pend <= 1'b0;
					state    <= st_idle;
				end
				st_read_snd: begin
					snd_done <= 1'b1;
					snd_pend <= 1'b0;
					state    <= st_idle;
				end
				default: state <= st_idle;
			endcase
			// A fresh request outranks the clear above
			if (cpu_req)
				cpu_pend <= 1'b1;
			if (snd_req)
				snd_pend <= 1'b1;
		end
	end

	// Latched request addresses and download write
	always_ff @(posedge clk_sys) begin
		if (cpu_req)
			cpu_addr_r <= cpu_addr;
		if (snd_req)
			snd_addr_r <= snd_addr;
		if (dl_wr) begin
			wr_addr_r <= dl_addr[15:1];
			wr_data_r <= dl_data;
			wr_hi_r   <= dl_addr[0];
		end
	end

	//============================================================
	// Array access
	//============================================================
	always_ff @(posedge clk_sys) begin
		if (wr_pend) begin
			// Bytes beyond the store are dropped
			if (wr_addr_r < `STORE_WORDS) begin
				if (wr_hi_r)
					mem[wr_addr_r][15:8] <= wr_data_r;
				else
					mem[wr_addr_r][7:0] <= wr_data_r;
			end
		end else if (state == st_read_cpu) begin
			q <= mem[cpu_addr_r];
		end else if (state == st_read_snd) begin
			q <= mem[snd_addr_r];
		end
	end

endmodule

`default_nettype wire

// ==== design/core_reset.sv ====
// Holds the core in reset until the first download has finished.
// A soft reset request reasserts it with one cycle of latency.
`default_nettype none

module core_reset (
	input  wire logic clk_sys,
	input  wire logic rst_n,
	input  wire logic download,
	input  wire logic soft_reset,
	output logic      core_reset
);

	logic download_q; // Previous download level
	logic rom_loaded; // Sticky after the first download

	//============================================================
	// Download completion
	//============================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			download_q <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			download_q <= download;
			if (download_q && !download)
				rom_loaded <= 1'b1; // Falling edge of download
		end
	end

	// Registered reset to the core
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			core_reset <= 1'b1;
		else
			core_reset <= soft_reset | ~rom_loaded;
	end

endmodule

`default_nettype wire

// ==== design/key_mapper.sv ====
// Keyboard buttons held from make and break strobes, merged with two joysticks.
// Unknown scan codes are ignored; extended prefixes must be stripped upstream.
`default_nettype none

`include "rom_defs.svh"

module key_mapper import arcade_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	input  wire logic       key_strobe,
	input  wire logic       key_pressed,
	input  wire scan_code_t key_code,
	input  wire joy_t       joystick_0,
	input  wire joy_t       joystick_1,
	output logic            up,
	output logic            down,
	output logic            left,
	output logic            right,
	output logic            fire,
	output logic            coin,
	output logic            start1,
	output logic            start2
);

	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_fire;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;

	//============================================================
	// Held key levels
	//============================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_fire   <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				`KEY_UP:     btn_up     <= key_pressed;
				`KEY_DOWN:   btn_down   <= key_pressed;
				`KEY_LEFT:   btn_left   <= key_pressed;
				`KEY_RIGHT:  btn_right  <= key_pressed;
				`KEY_FIRE:   btn_fire   <= key_pressed;
				`KEY_COIN:   btn_coin   <= key_pressed;
				`KEY_START1: btn_start1 <= key_pressed;
				`KEY_START2: btn_start2 <= key_pressed;
				default: ; // Not a game key
			endcase
		end
	end

	// Either joystick drives the shared controls
	assign up     = btn_up    | joystick_0[3] | joystick_1[3];
	assign down   = btn_down  | joystick_0[2] | joystick_1[2];
	assign left   = btn_left  | joystick_0[1] | joystick_1[1];
	assign right  = btn_right | joystick_0[0] | joystick_1[0];
	assign fire   = btn_fire  | joystick_0[4] | joystick_1[4];
	assign coin   = btn_coin;
	assign start1 = btn_start1;
	assign start2 = btn_start2;

endmodule

`default_nettype wire

// ==== design/arcade_rom_subsys.sv ====
// ROM serving and control side of the arcade wrapper; the game core sits outside.
// Download bytes at 16'h8000 and up land in the sound region of the store.
// cpu_rom_data and snd_rom_data are valid once the matching wait output is low.
`default_nettype none

`include "rom_defs.svh"

module arcade_rom_subsys import arcade_pkg::*; (
	input  wire logic                   clk_sys,
	input  wire logic                   rst_n,
	// Download stream
	input  wire logic                   download,
	input  wire logic                   dl_wr,
	input  wire dl_addr_t               dl_addr,
	input  wire rom_byte_t              dl_data,
	// Core ROM buses
	input  wire logic                   cpu_rom_rd,
	input  wire logic [`CPU_ROM_AW-1:0] cpu_rom_addr,
	output rom_byte_t                   cpu_rom_data,
	output logic                        cpu_rom_wait,
	input  wire logic                   snd_rom_rd,
	input  wire logic [`SND_ROM_AW-1:0] snd_rom_addr,
	output rom_byte_t                   snd_rom_data,
	output logic                        snd_rom_wait,
	// Reset and status
	input  wire logic                   soft_reset,
	output logic                        core_reset,
	output logic                        led,
	// Controls
	input  wire logic                   key_strobe,
	input  wire logic                   key_pressed,
	input  wire scan_code_t             key_code,
	input  wire joy_t                   joystick_0,
	input  wire joy_t                   joystick_1,
	output logic                        up,
	output logic                        down,
	output logic                        left,
	output logic                        right,
	output logic                        fire,
	output logic                        coin,
	output logic                        start1,
	output logic                        start2
);

	logic        cpu_req;
	logic        snd_req;
	logic        cpu_done;
	logic        snd_done;
	store_addr_t cpu_word_addr;
	store_addr_t snd_word_addr;
	rom_word_t   store_q; // Shared by both clients

	//============================================================
	// Core ROM ports
	//============================================================
	rom_port #(.ADDR_W(`CPU_ROM_AW), .BASE_WORD(0)) cpu_port (
		.clk_sys(clk_sys), .rst_n(rst_n), .download(download),
		.rd(cpu_rom_rd), .addr(cpu_rom_addr),
		.done(cpu_done), .q(store_q),
		.req(cpu_req), .word_addr(cpu_word_addr),
		.data(cpu_rom_data), .wait_rom(cpu_rom_wait)
	);

	rom_port #(.ADDR_W(`SND_ROM_AW), .BASE_WORD(`SND_BASE_WORD)) snd_port (
		.clk_sys(clk_sys), .rst_n(rst_n), .download(download),
		.rd(snd_rom_rd), .addr(snd_rom_addr),
		.done(snd_done), .q(store_q),
		.req(snd_req), .word_addr(snd_word_addr),
		.data(snd_rom_data), .wait_rom(snd_rom_wait)
	);

	//============================================================
	// Shared store
	//============================================================
	rom_store u_store (
		.clk_sys(clk_sys), .rst_n(rst_n), .download(download),
		.dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.cpu_req(cpu_req), .cpu_addr(cpu_word_addr),
		.snd_req(snd_req), .snd_addr(snd_word_addr),
		.cpu_done(cpu_done), .snd_done(snd_done), .q(store_q)
	);

	// Core reset and controls
	core_reset u_core_reset (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.download(download), .soft_reset(soft_reset),
		.core_reset(core_reset)
	);

	key_mapper u_keys (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.up(up), .down(down), .left(left), .right(right), .fire(fire),
		.coin(coin), .start1(start1), .start2(start2)
	);

	assign led = ~download; // Dark while downloading

endmodule

`default_nettype wire

// ==== test/tb_arcade_rom_subsys.sv ====
// Self-checking testbench for the ROM subsystem.
// Downloads 48K random bytes, then checks core reset, both ROM buses and the key mapping.
// Inputs are driven and outputs sampled 1 ns after the rising clock edge.
`default_nettype none

`include "rom_defs.svh"

module tb_arcade_rom_subsys import arcade_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int rom_bytes      = 2 * `STORE_WORDS;
	localparam int timeout_cycles = 20; // Limit for any read

	logic                   clk_sys;
	logic                   rst_n;
	logic                   download;
	logic                   dl_wr;
	dl_addr_t               dl_addr;
	rom_byte_t              dl_data;
	logic                   cpu_rom_rd;
	logic [`CPU_ROM_AW-1:0] cpu_rom_addr;
	rom_byte_t              cpu_rom_data;
	logic                   cpu_rom_wait;
	logic                   snd_rom_rd;
	logic [`SND_ROM_AW-1:0] snd_rom_addr;
	rom_byte_t              snd_rom_data;
	logic                   snd_rom_wait;
	logic                   soft_reset;
	logic                   core_reset;
	logic                   led;
	logic                   key_strobe;
	logic                   key_pressed;
	scan_code_t             key_code;
	joy_t                   joystick_0;
	joy_t                   joystick_1;
	logic                   up;
	logic                   down;
	logic                   left;
	logic                   right;
	logic                   fire;
	logic                   coin;
	logic                   start1;
	logic                   start2;

	rom_byte_t   rom_image [0:rom_bytes-1];
	scan_code_t  key_codes [0:7];
	integer      seed;
	int          errors;
	int          checks;
	int          cpu_last_word; // Last fetched word per bus or -1 to force a fetch
	int          snd_last_word;
	logic [7:0]  held_keys;     // Same order as the control outputs

	// Reads waiting for the checker
	logic        log_bus [$];
	logic [15:0] log_addr [$];
	rom_byte_t   log_data [$];
	event        read_logged;

	arcade_rom_subsys DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	//============================================================
	// Reference model
	//============================================================
	// Sound bus byte 0 sits at download byte 16'h8000
	function automatic rom_byte_t expected_byte(input logic snd, input logic [15:0] addr);
		int idx;
		idx = snd ? 32'h8000 + int'(addr) : int'(addr);
		return rom_image[idx];
	endfunction

	function automatic logic [7:0] key_mask(input scan_code_t code);
		case (code)
			`KEY_UP:     return 8'b1000_0000;
			`KEY_DOWN:   return 8'b0100_0000;
			`KEY_LEFT:   return 8'b0010_0000;
			`KEY_RIGHT:  return 8'b0001_0000;
			`KEY_FIRE:   return 8'b0000_1000;
			`KEY_COIN:   return 8'b0000_0100;
			`KEY_START1: return 8'b0000_0010;
			`KEY_START2: return 8'b0000_0001;
			default:     return 8'b0000_0000;
		endcase
	endfunction

	// {up, down, left, right, fire, coin, start1, start2}
	function automatic logic [7:0] expected_controls(input logic [7:0] held, input joy_t j0,
			input joy_t j1);
		joy_t j;
		j = j0 | j1;
		return held | {j[3], j[2], j[1], j[0], j[4], 3'b000};
	endfunction

	//============================================================
	// Helpers
	//============================================================
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout: %s did not happen in time", what);
		$display("Checks: %0d, errors: %0d, timeouts: 1", checks, errors);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic check_controls();
		check_value("controls", 16'({up, down, left, right, fire, coin, start1, start2}),
			16'(expected_controls(held_keys, joystick_0, joystick_1)));
	endtask

	// Steps until both waits are low, counting the cycles each was high
	task automatic wait_reads(output int cpu_cyc, output int snd_cyc);
		cpu_cyc = 0;
		snd_cyc = 0;
		repeat (timeout_cycles) begin
			tick();
			if (cpu_rom_wait)
				cpu_cyc++;
			if (snd_rom_wait)
				snd_cyc++;
			if (!cpu_rom_wait && !snd_rom_wait)
				return;
		end
		fail_timeout("release of the ROM wait outputs");
	endtask

	task automatic await_reset_level(input logic level);
		repeat (4) begin
			tick();
			if (core_reset == level)
				return;
		end
		fail_timeout(level ? "rise of core_reset" : "fall of core_reset");
	endtask

	task automatic log_read(input logic snd, input logic [15:0] addr, input rom_byte_t data);
		log_bus.push_back(snd);
		log_addr.push_back(addr);
		log_data.push_back(data);
		-> read_logged;
	endtask

	// A new word holds wait for 3 cycles and the held word for none
	task automatic single_read(input logic snd, input logic [14:0] addr);
		int cpu_cyc;
		int snd_cyc;
		int exp_cyc;
		int word;
		word = int'(addr[14:1]);
		if (snd) begin
			exp_cyc       = (word == snd_last_word) ? 0 : 3;
			snd_last_word = word;
			snd_rom_rd    = 1'b1;
			snd_rom_addr  = addr[13:0];
		end else begin
			exp_cyc       = (word == cpu_last_word) ? 0 : 3;
			cpu_last_word = word;
			cpu_rom_rd    = 1'b1;
			cpu_rom_addr  = addr;
		end
		wait_reads(cpu_cyc, snd_cyc);
		check_value("wait cycles", 16'(snd ? snd_cyc : cpu_cyc), 16'(exp_cyc));
		log_read(snd, 16'(addr), snd ? snd_rom_data : cpu_rom_data);
		cpu_rom_rd = 1'b0;
		snd_rom_rd = 1'b0;
	endtask

	// Both buses in the same cycle; sound waits behind the CPU
	task automatic paired_read(input logic [14:0] cpu_addr, input logic [13:0] snd_addr);
		int cpu_cyc;
		int snd_cyc;
		if (int'(cpu_addr[14:1]) == cpu_last_word)
			cpu_addr[1] = ~cpu_addr[1];
		if (int'(snd_addr[13:1]) == snd_last_word)
			snd_addr[1] = ~snd_addr[1];
		cpu_last_word = int'(cpu_addr[14:1]);
		snd_last_word = int'(snd_addr[13:1]);
		cpu_rom_rd    = 1'b1;
		cpu_rom_addr  = cpu_addr;
		snd_rom_rd    = 1'b1;
		snd_rom_addr  = snd_addr;
		wait_reads(cpu_cyc, snd_cyc);
		check_value("cpu wait cycles", 16'(cpu_cyc), 16'd3);
		check_value("sound wait cycles", 16'(snd_cyc), 16'd5);
		log_read(1'b0, 16'(cpu_rom_addr), cpu_rom_data);
		log_read(1'b1, 16'(snd_rom_addr), snd_rom_data);
		cpu_rom_rd = 1'b0;
		snd_rom_rd = 1'b0;
	endtask

	task automatic other_byte_read(input logic snd);
		if (snd) begin
			snd_rom_rd      = 1'b1;
			snd_rom_addr[0] = ~snd_rom_addr[0];
		end else begin
			cpu_rom_rd      = 1'b1;
			cpu_rom_addr[0] = ~cpu_rom_addr[0];
		end
		repeat (3) begin
			tick();
			check_value("wait on held word", 16'(snd ? snd_rom_wait : cpu_rom_wait), 16'h0);
		end
		log_read(snd, snd ? 16'(snd_rom_addr) : 16'(cpu_rom_addr),
			snd ? snd_rom_data : cpu_rom_data);
		cpu_rom_rd = 1'b0;
		snd_rom_rd = 1'b0;
	endtask

	task automatic key_event(input scan_code_t code, input logic pressed);
		key_strobe  = 1'b1;
		key_code    = code;
		key_pressed = pressed;
		tick();
		key_strobe = 1'b0;
		if (pressed)
			held_keys = held_keys | key_mask(code);
		else
			held_keys = held_keys & ~key_mask(code);
		check_controls();
	endtask

	// Read checker against the reference bytes
	initial begin
		logic        snd;
		logic [15:0] addr;
		rom_byte_t   data;
		forever begin
			@(read_logged);
			while (log_bus.size() > 0) begin
				snd  = log_bus.pop_front();
				addr = log_addr.pop_front();
				data = log_data.pop_front();
				check_value($sformatf("%s byte at %h", snd ? "sound" : "cpu", addr),
					16'(data), 16'(expected_byte(snd, addr)));
			end
		end
	end

	//============================================================
	// Stimulus
	//============================================================
	initial begin
		int i;
		int rnd;
		seed          = 32'h66ac4623;
		errors        = 0;
		checks        = 0;
		cpu_last_word = -1;
		snd_last_word = -1;
		held_keys     = 8'h00;
		rst_n         = 1'b0;
		download      = 1'b0;
		dl_wr         = 1'b0;
		dl_addr       = '0;
		dl_data       = '0;
		cpu_rom_rd    = 1'b0;
		cpu_rom_addr  = '0;
		snd_rom_rd    = 1'b0;
		snd_rom_addr  = '0;
		soft_reset    = 1'b0;
		key_strobe    = 1'b0;
		key_pressed   = 1'b0;
		key_code      = '0;
		joystick_0    = '0;
		joystick_1    = '0;
		key_codes = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT,
			`KEY_FIRE, `KEY_COIN, `KEY_START1, `KEY_START2};
		for (i = 0; i < rom_bytes; i++) begin
			rnd          = $random(seed);
			rom_image[i] = rnd[7:0];
		end
		repeat (2) tick();
		rst_n = 1'b1;
		check_value("core_reset after reset", 16'(core_reset), 16'h1);
		check_value("led after reset", 16'(led), 16'h1);

		// Download one byte per cycle
		download = 1'b1;
		for (i = 0; i < rom_bytes; i++) begin
			dl_wr   = 1'b1;
			dl_addr = dl_addr_t'(i);
			dl_data = rom_image[i];
			tick();
		end
		dl_wr = 1'b0;
		repeat (2) tick(); // Last write commits
		check_value("core_reset during download", 16'(core_reset), 16'h1);
		check_value("led during download", 16'(led), 16'h0);
		download = 1'b0;
		await_reset_level(1'b0);

		// Soft reset holds the core
		soft_reset = 1'b1;
		await_reset_level(1'b1);
		repeat (3) begin
			tick();
			check_value("core_reset in soft reset", 16'(core_reset), 16'h1);
		end
		soft_reset = 1'b0;
		await_reset_level(1'b0);

		// ROM reads
		repeat (40) begin
			rnd = $random(seed);
			single_read(1'b0, rnd[14:0]);
		end
		repeat (40) begin
			rnd = $random(seed);
			single_read(1'b1, {1'b0, rnd[13:0]});
		end
		repeat (20) begin
			rnd = $random(seed);
			paired_read(rnd[14:0], rnd[29:16]);
		end
		repeat (10) begin
			rnd = $random(seed);
			single_read(1'b0, rnd[14:0]);
			other_byte_read(1'b0);
			single_read(1'b1, {1'b0, rnd[29:16]});
			other_byte_read(1'b1);
		end

		// Keys followed by unknown codes and joysticks
		for (i = 0; i < 8; i++) begin
			key_event(key_codes[i], 1'b1);
			key_event(key_codes[i], 1'b0);
		end
		key_event(`KEY_FIRE, 1'b1);
		key_event(`KEY_LEFT, 1'b1);
		key_event(8'h1C, 1'b1);
		key_event(8'hE0, 1'b0);
		key_event(8'h00, 1'b1);
		repeat (8) begin
			rnd        = $random(seed);
			joystick_0 = rnd[7:0];
			joystick_1 = rnd[15:8];
			tick();
			check_controls();
		end
		key_event(`KEY_FIRE, 1'b0);
		key_event(`KEY_LEFT, 1'b0);

		tick();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
design/arcade_pkg.sv
design/rom_port.sv
design/rom_store.sv
design/core_reset.sv
design/key_mapper.sv
design/arcade_rom_subsys.sv
test/tb_arcade_rom_subsys.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_arcade_rom_subsys
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
